/* vlog.f */
+incdir+include
hw/a429_pkg.sv
hw/a429_bit_decoder.sv
hw/a429_word_assembler.sv
hw/a429_label_filter.sv
hw/a429_word_fifo.sv
hw/a429_rx_top.sv
dv/a429_rx_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f vlog.f --top-module a429_rx_tb -Mdir obj_dir

out=$(./obj_dir/Va429_rx_tb)
echo "$out"

if echo "$out" | grep -q "^All checks passed$"; then
	exit 0
else
	exit 1
fi

/* dv/a429_rx_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "a429_macros.svh"

module a429_rx_tb;

	localparam int RDY_TIMEOUT = 3000; // in clock cycles and longer than any word tail

	logic clk = 1'b0;
	logic rst;
	logic hi;
	logic lo;
	a429_pkg::speed_t speed;
	logic label_we;
	logic [7:0] label_addr;
	logic label_en;
	logic rd;
	logic rdy;
	a429_pkg::a429_word_t rd_data;
	logic overflow;
	logic [`A429_ERR_W-1:0] parity_err_count;

	logic [31:0] lcg_state;
	int pass_count;
	int fail_count;

	a429_rx_top UUT (.*);

	initial
	begin
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state ^ (lcg_state >> 16); // the low bits of a plain LCG repeat quickly
	endfunction

	// the parity bit makes the count of ones in the word odd
	function automatic a429_pkg::a429_word_t with_odd_parity(input a429_pkg::a429_word_t w);
		w.parity = ~(^w[30:0]);
		return w;
	endfunction

	function automatic a429_pkg::a429_word_t random_word();
		return with_odd_parity(a429_pkg::a429_word_t'(lcg_next()));
	endfunction

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp)
		begin
			$display("[ERROR] t=%0t %s expected 0x%0h actual 0x%0h", $time, name, exp, act);
			fail_count++;
		end
		else
			pass_count++;
	endtask

	task automatic report_failure(input string msg);
		$display("t=%0t %s", $time, msg);
		fail_count++;
	endtask

	task automatic check_word(input a429_pkg::a429_word_t exp);
		check_val("rd_data.label", exp.label, rd_data.label);
		check_val("rd_data.sdi", exp.sdi, rd_data.sdi);
		check_val("rd_data.data", exp.data, rd_data.data);
		check_val("rd_data.ssm", exp.ssm, rd_data.ssm);
		check_val("rd_data.parity", exp.parity, rd_data.parity);
	endtask

	// the label goes out MSB first and word bits 9 to 32 follow in order
	// an extra pulse on both lines goes out just before bit illegal_bit
	task automatic send_word(input a429_pkg::a429_word_t w, input int n_bits,
		input int illegal_bit, input bit flip_parity);
		int half;
		logic b;
		half = `A429_CLK_HZ / (2 * ((speed == a429_pkg::SPEED_HI) ? `A429_RATE_HI : `A429_RATE_LO));
		if (flip_parity)
			w.parity = ~w.parity;
		@(negedge clk);
		hi = 1'b0;
		lo = 1'b0;
		repeat (8 * half) @(negedge clk);
		for (int i = 0; i < n_bits; i++)
		begin
			if (i == illegal_bit)
			begin
				hi = 1'b1;
				lo = 1'b1;
				repeat (half) @(negedge clk);
				hi = 1'b0;
				lo = 1'b0;
				repeat (half) @(negedge clk);
			end
			b = (i < 8) ? w.label[7 - i] : w[i];
			hi = b;
			lo = !b;
			repeat (half) @(negedge clk);
			hi = 1'b0;
			lo = 1'b0;
			repeat (half) @(negedge clk);
		end
	endtask

	task automatic wait_rdy(output bit seen);
		int n;
		n = 0;
		while (!rdy && n < RDY_TIMEOUT)
		begin
			@(negedge clk);
			n++;
		end
		seen = rdy;
	endtask

	task automatic pop_word();
		rd = 1'b1;
		@(negedge clk);
		rd = 1'b0;
	endtask

	task automatic read_expect(input a429_pkg::a429_word_t exp);
		bit seen;
		wait_rdy(seen);
		if (!seen)
			report_failure("timed out waiting for rdy");
		else
		begin
			check_word(exp);
			pop_word();
		end
	endtask

	task automatic expect_none();
		bit seen;
		wait_rdy(seen);
		if (seen)
		begin
			report_failure("rdy rose although no word should have been accepted");
			pop_word();
		end
	endtask

	task automatic set_label(input logic [7:0] addr, input logic en);
		@(negedge clk);
		label_we = 1'b1;
		label_addr = addr;
		label_en = en;
		@(negedge clk);
		label_we = 1'b0;
	endtask

	task automatic report_test(input string name, input int fails_before);
		$display("test %-16s %s", name, (fail_count == fails_before) ? "ok" : "FAILED");
	endtask

	task automatic test_basic();
		a429_pkg::a429_word_t w [3];
		int f0;
		f0 = fail_count;
		for (int i = 0; i < 3; i++)
		begin
			w[i] = random_word();
			send_word(w[i], 32, -1, 1'b0);
		end
		for (int i = 0; i < 3; i++)
			read_expect(w[i]);
		report_test("basic receive", f0);
	endtask

	task automatic test_parity();
		a429_pkg::a429_word_t w;
		int f0;
		f0 = fail_count;
		check_val("parity_err_count", 0, parity_err_count); // only good words so far
		w = random_word();
		send_word(w, 32, -1, 1'b1);
		expect_none();
		check_val("parity_err_count", 1, parity_err_count);
		w = random_word();
		send_word(w, 32, -1, 1'b0);
		read_expect(w);
		report_test("parity", f0);
	endtask

	task automatic test_label();
		a429_pkg::a429_word_t w;
		int f0;
		f0 = fail_count;
		w = random_word();
		set_label(w.label, 1'b0);
		send_word(w, 32, -1, 1'b0);
		expect_none();
		set_label(w.label, 1'b1);
		send_word(w, 32, -1, 1'b0);
		read_expect(w);
		report_test("label filter", f0);
	endtask

	task automatic test_broken();
		a429_pkg::a429_word_t w;
		int f0;
		f0 = fail_count;
		w = random_word();
		send_word(w, 20, -1, 1'b0);
		send_word(w, 32, 13, 1'b0); // a pulse on both lines comes before bit 14
		w = random_word();
		send_word(w, 32, -1, 1'b0);
		read_expect(w);
		expect_none();
		report_test("broken words", f0);
	endtask

	task automatic test_overflow();
		a429_pkg::a429_word_t w [`A429_FIFO_DEPTH + 1];
		int f0;
		f0 = fail_count;
		for (int i = 0; i < `A429_FIFO_DEPTH; i++)
		begin
			w[i] = random_word();
			send_word(w[i], 32, -1, 1'b0);
		end
		check_val("overflow", 0, overflow); // full but nothing dropped yet
		w[`A429_FIFO_DEPTH] = random_word();
		send_word(w[`A429_FIFO_DEPTH], 32, -1, 1'b0);
		check_val("overflow", 1, overflow);
		for (int i = 0; i < `A429_FIFO_DEPTH; i++)
			read_expect(w[i]);
		expect_none();
		report_test("overflow", f0);
	endtask

	task automatic test_speed();
		a429_pkg::a429_word_t w;
		int f0;
		f0 = fail_count;
		@(negedge clk);
		speed = a429_pkg::SPEED_LO;
		w = random_word();
		send_word(w, 32, -1, 1'b0);
		read_expect(w);
		report_test("low speed", f0);
	endtask

	initial
	begin
		lcg_state = 32'd60;
		pass_count = 0;
		fail_count = 0;
		rst = 1'b1;
		hi = 1'b0;
		lo = 1'b0;
		speed = a429_pkg::SPEED_HI;
		label_we = 1'b0;
		label_addr = '0;
		label_en = 1'b0;
		rd = 1'b0;
		repeat (5) @(negedge clk);
		rst = 1'b0;
		test_basic();
		test_parity();
		test_label();
		test_broken();
		test_overflow();
		test_speed();
		$display("checks passing %0d, checks failing %0d", pass_count, fail_count);
		if (fail_count == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

/* hw/a429_rx_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "a429_macros.svh"

module a429_rx_top (
	input logic clk,
	input logic rst,
	input logic hi,
	input logic lo,
	input a429_pkg::speed_t speed,
	input logic label_we,
	input logic [7:0] label_addr,
	input logic label_en,
	input logic rd,
	output logic rdy,
	output a429_pkg::a429_word_t rd_data,
	output logic overflow,
	output logic [`A429_ERR_W-1:0] parity_err_count
);

	a429_pkg::line_bit_t line;
	logic word_valid;
	a429_pkg::a429_word_t word;
	logic push;
	a429_pkg::a429_word_t push_word;

	a429_bit_decoder u_decoder (
		.clk(clk),
		.rst(rst),
		.hi(hi),
		.lo(lo),
		.speed(speed),
		.line(line)
	);

	a429_word_assembler u_assembler (
		.clk(clk),
		.rst(rst),
		.line(line),
		.word_valid(word_valid),
		.word(word)
	);

	a429_label_filter u_filter (
		.clk(clk),
		.rst(rst),
		.word_valid(word_valid),
		.word(word),
		.label_we(label_we),
		.label_addr(label_addr),
		.label_en(label_en),
		.push(push),
		.push_word(push_word),
		.parity_err_count(parity_err_count)
	);

	a429_word_fifo #(
		.payload_t(a429_pkg::a429_word_t)
	) u_fifo (
		.clk(clk),
		.rst(rst),
		.push(push),
		.push_data(push_word),
		.rd(rd),
		.rdy(rdy),
		.rd_data(rd_data),
		.overflow(overflow)
	);

endmodule

`default_nettype wire

/* hw/a429_word_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

`include "a429_macros.svh"

module a429_word_fifo #(
	parameter type payload_t = logic [31:0]
) (
	input logic clk,
	input logic rst,
	input logic push,
	input payload_t push_data,
	input logic rd,
	output logic rdy,
	output payload_t rd_data,
	output logic overflow
);

	localparam int DEPTH = `A429_FIFO_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic full;
	logic do_pop;
	logic do_push;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign rdy = (count != '0);
	assign full = (count == CNT_W'(DEPTH));
	assign rd_data = mem[rd_ptr];
	assign do_pop = rd & rdy;
	assign do_push = push & (~full | do_pop); // a pop frees the slot in the same cycle

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			overflow <= 1'b0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (do_pop)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			if (push && !do_push)
				overflow <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

endmodule

`default_nettype wire

/* hw/a429_label_filter.sv */
`timescale 1ns/100ps
`default_nettype none

`include "a429_macros.svh"

module a429_label_filter (
	input logic clk,
	input logic rst,
	input logic word_valid,
	input a429_pkg::a429_word_t word,
	input logic label_we,
	input logic [7:0] label_addr,
	input logic label_en,
	output logic push,
	output a429_pkg::a429_word_t push_word,
	output logic [`A429_ERR_W-1:0] parity_err_count
);

	logic [255:0] en_tbl;
	logic parity_ok;

	// odd parity over the whole word
	assign parity_ok = ^word;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			en_tbl <= '1;
			push <= 1'b0;
			parity_err_count <= '0;
		end
		else
		begin
			if (label_we)
				en_tbl[label_addr] <= label_en;

			push <= word_valid & parity_ok & en_tbl[word.label];

			if (word_valid && !parity_ok && parity_err_count != '1)
				parity_err_count <= parity_err_count + 1'b1; // saturates at all ones
		end
	end

	always_ff @(posedge clk)
	begin
		if (word_valid)
			push_word <= word;
	end

endmodule

`default_nettype wire

/* hw/a429_word_assembler.sv */
`timescale 1ns/100ps
`default_nettype none

module a429_word_assembler (
	input logic clk,
	input logic rst,
	input a429_pkg::line_bit_t line,
	output logic word_valid,
	output a429_pkg::a429_word_t word
);

	logic armed;
	logic [5:0] bit_cnt;
	logic [31:0] word_bits;

	assign word = a429_pkg::a429_word_t'(word_bits);

	// control state
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			armed <= 1'b0;
			bit_cnt <= '0;
			word_valid <= 1'b0;
		end
		else
		begin
			word_valid <= 1'b0;
			if (line.illegal)
			begin
				armed <= 1'b0; // the word is lost and a gap must come first
				bit_cnt <= '0;
			end
			else if (line.gap)
			begin
				armed <= 1'b1;
				bit_cnt <= '0;
			end
			else if (line.bit_stb && armed)
			begin
				bit_cnt <= bit_cnt + 1'b1;
				if (bit_cnt == 6'd31)
				begin
					word_valid <= 1'b1;
					armed <= 1'b0;
				end
			end
		end
	end

	// the label arrives MSB first, the rest lands by position
	always_ff @(posedge clk)
	begin
		if (line.bit_stb && armed && !line.illegal && !line.gap)
		begin
			if (bit_cnt < 6'd8)
				word_bits[7:0] <= {word_bits[6:0], line.value};
			else
				word_bits[bit_cnt[4:0]] <= line.value;
		end
	end

endmodule

`default_nettype wire

/* hw/a429_bit_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

`include "a429_macros.svh"

module a429_bit_decoder (
	input logic clk,
	input logic rst,
	input logic hi,
	input logic lo,
	input a429_pkg::speed_t speed,
	output a429_pkg::line_bit_t line
);

	localparam int HALF_HI = `A429_CLK_HZ / (2 * `A429_RATE_HI);
	localparam int HALF_LO = `A429_CLK_HZ / (2 * `A429_RATE_LO);
	localparam int DIV_W = $clog2(HALF_LO);
	localparam int NULL_W = $clog2(`A429_GAP_TICKS + 1);

	logic [1:0] hi_sync;
	logic [1:0] lo_sync;
	logic hi_s;
	logic lo_s;
	logic hi_q;
	logic lo_q;
	logic pulse_start;
	logic both_rise;
	logic null_now;
	logic [DIV_W-1:0] half_m1;
	logic [DIV_W-1:0] div_cnt;
	logic tick;
	logic [NULL_W-1:0] null_cnt;

	assign hi_s = hi_sync[1];
	assign lo_s = lo_sync[1];
	assign null_now = ~hi_s & ~lo_s;

	// a pulse starts when either line leaves null
	assign pulse_start = (hi_s | lo_s) & ~(hi_q | lo_q);
	assign both_rise = hi_s & lo_s & ~(hi_q & lo_q);

	assign half_m1 = (speed == a429_pkg::SPEED_HI) ? DIV_W'(HALF_HI - 1) : DIV_W'(HALF_LO - 1);
	assign tick = (div_cnt == half_m1);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			hi_sync <= '0;
			lo_sync <= '0;
			hi_q <= 1'b0;
			lo_q <= 1'b0;
			div_cnt <= '0;
			null_cnt <= '0;
			line <= '0;
		end
		else
		begin
			hi_sync <= {hi_sync[0], hi};
			lo_sync <= {lo_sync[0], lo};
			hi_q <= hi_s;
			lo_q <= lo_s;

			// the divider is realigned to every pulse so ticks fall on half-bit edges
			if (pulse_start || tick)
				div_cnt <= '0;
			else
				div_cnt <= div_cnt + 1'b1;

			if (!null_now)
				null_cnt <= '0;
			else if (tick && null_cnt != NULL_W'(`A429_GAP_TICKS))
				null_cnt <= null_cnt + 1'b1; // holds at the limit so the gap fires once

			line.bit_stb <= pulse_start & ~(hi_s & lo_s);
			line.value <= hi_s;
			line.gap <= tick & null_now & (null_cnt == NULL_W'(`A429_GAP_TICKS - 1));
			line.illegal <= both_rise;
		end
	end

endmodule

`default_nettype wire

/* hw/a429_pkg.sv */
`default_nettype none

package a429_pkg;

	// selects the half-bit period, CLK_HZ / (2 * rate)
	typedef enum logic
	{
		SPEED_HI,
		SPEED_LO
	} speed_t;

	// bit 32 down to bit 1, the label holds the first bit received in its MSB
	typedef struct packed
	{
		logic parity;
		logic [1:0] ssm;
		logic [18:0] data; // LSB is received bit 11
		logic [1:0] sdi;
		logic [7:0] label;
	} a429_word_t;

	// one-cycle strobes from the decoder
	typedef struct packed
	{
		logic bit_stb;
		logic value; // 1 for a pulse on HI, 0 for a pulse on LO
		logic gap;
		logic illegal;
	} line_bit_t;

endpackage

`default_nettype wire

/* include/a429_macros.svh */
`ifndef A429_MACROS_SVH
`define A429_MACROS_SVH

// system clock in Hz
`define A429_CLK_HZ 50000000

// line rates in bits per second
`define A429_RATE_HI 100000
`define A429_RATE_LO 12500

// half-bit ticks of continuous null that end a word, three bit times
`define A429_GAP_TICKS 6

// received words held for the host
`define A429_FIFO_DEPTH 4

// width of the saturating parity error counter
`define A429_ERR_W 8

`endif
